// ==== verilog.f ====
+incdir+.
ext_pkg.sv
ext_group_if.sv
ext_branch_decode.sv
ext_group_former.sv
ext_flow_select.sv
ext_skid_reg.sv
ext_top.sv
tb_ext_top.sv

// ==== Bender.yml ====
package:
  name: ext_stage

sources:
  - include_dirs:
      - .
    files:
      - ext_pkg.sv
      - ext_group_if.sv
      - ext_branch_decode.sv
      - ext_group_former.sv
      - ext_flow_select.sv
      - ext_skid_reg.sv
      - ext_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ext_top.sv

// ==== tb_ext_model.svh ====
// Reference model and random group generator for the extract-stage testbench
// Included inside the testbench module after the package import
`ifndef TB_EXT_MODEL_SVH
`define TB_EXT_MODEL_SVH

localparam int WIN_BITS     = `EXT_SLOTS * `EXT_INSN_BITS;
localparam int WIN_PARCELS  = WIN_BITS / `EXT_PARCEL_BITS;
localparam int LINE_PARCELS = `EXT_LINE_BITS / `EXT_PARCEL_BITS;
localparam logic [`EXT_PC_BITS-1:0] SLOT_BYTES = `EXT_INSN_BITS / 8;

// ====================
// Reference model
// ====================

// Window cut parcel by parcel, parcels past the line end read as zero
function automatic logic [WIN_BITS-1:0] align_window(logic [`EXT_LINE_BITS-1:0] line,
		logic [`EXT_PC_BITS-1:0] pc);
	logic [WIN_BITS-1:0] win;
	int                  first;
	int                  p;
	win = '0;
	// PC bits 5 to 1 pick the starting parcel
	first = pc[5:1];
	for (int k = 0; k < WIN_PARCELS; k++) begin
		p = first + k;
		if (p < LINE_PARCELS)
			win[k*`EXT_PARCEL_BITS +: `EXT_PARCEL_BITS] = line[p*`EXT_PARCEL_BITS +: `EXT_PARCEL_BITS];
	end
	return win;
endfunction

// Valid bits from irq, repeat, branch miss and single step
function automatic slot_mask_t expect_mask(logic [`EXT_PC_BITS-1:0] pc, logic irq,
		logic redundant, logic miss, logic [`EXT_PC_BITS-1:0] mpc, logic ssm, logic prev_ssm);
	slot_mask_t m;
	for (int n = 0; n < `EXT_SLOTS; n++) begin
		m[n] = !(irq || redundant);
		if (miss && (mpc > pc + SLOT_BYTES * n))
			m[n] = 1'b0;
		if (ssm && ((n > 0) || prev_ssm))
			m[n] = 1'b0;
	end
	return m;
endfunction

// First jump or return among valid slots, return address of first valid call
function automatic flow_t expect_flow(group_t g);
	flow_t                   f;
	logic [`EXT_INSN_BITS-1:0] w;
	logic [6:0]              op;
	logic [`EXT_PC_BITS-1:0] spc;
	logic                    taken;
	logic                    have_call;
	logic                    call;
	f.do_branch = 1'b0;
	f.do_call   = 1'b0;
	f.do_ret    = 1'b0;
	f.target    = `EXT_RESET_PC;
	f.ret_pc    = `EXT_RESET_PC;
	taken       = 1'b0;
	have_call   = 1'b0;
	for (int n = 0; n < `EXT_SLOTS; n++) begin
		w    = g.slots[n];
		op   = w[6:0];
		spc  = g.pc0 + SLOT_BYTES * n;
		call = (op == `EXT_OP_BSR) || (op == `EXT_OP_JSR);
		if (g.slot_valid[n]) begin
			if (!taken && (call || op == `EXT_OP_BCC)) begin
				taken       = 1'b1;
				f.do_branch = 1'b1;
				f.do_call   = call;
				// JSR takes absolute bits 38..7, others add disp in bits 47..16
				f.target    = (op == `EXT_OP_JSR) ? w[38:7] : spc + w[47:16];
			end else if (!taken && op == `EXT_OP_RTD) begin
				taken    = 1'b1;
				f.do_ret = 1'b1;
			end
			if (call && !have_call) begin
				have_call = 1'b1;
				f.ret_pc  = spc + SLOT_BYTES;
			end
		end
	end
	return f;
endfunction

// ====================
// Random stimulus
// ====================

// Opcode mix leans toward control flow
function automatic logic [`EXT_INSN_BITS-1:0] rand_insn();
	logic [`EXT_INSN_BITS-1:0] w;
	w = {16'($urandom), $urandom};
	case ($urandom_range(0, 9))
		0:       w      = '0;
		1:       w[6:0] = `EXT_OP_BSR;
		2:       w[6:0] = `EXT_OP_JSR;
		3:       w[6:0] = `EXT_OP_BCC;
		4:       w[6:0] = `EXT_OP_RTD;
		default: ;
	endcase
	return w;
endfunction

// Random line with biased instructions placed where the PC's slots fall
function automatic logic [`EXT_LINE_BITS-1:0] rand_line(logic [`EXT_PC_BITS-1:0] pc);
	logic [`EXT_LINE_BITS-1:0] line;
	logic [`EXT_LINE_BITS-1:0] ext_win;
	logic [`EXT_LINE_BITS-1:0] ext_mask;
	int                        sh;
	for (int i = 0; i < `EXT_LINE_BITS / 32; i++)
		line[i*32 +: 32] = $urandom;
	ext_win = '0;
	for (int n = 0; n < `EXT_SLOTS; n++)
		ext_win[n*`EXT_INSN_BITS +: `EXT_INSN_BITS] = rand_insn();
	ext_mask = {WIN_BITS{1'b1}};
	sh = pc[5:1] * `EXT_PARCEL_BITS;
	line = (line & ~(ext_mask << sh)) | (ext_win << sh);
	return line;
endfunction

`endif

// ==== tb_ext_top.sv ====
// Testbench for the instruction-extract stage
// Random fetch groups with back-pressure, each output checked in order
// against the reference model in the included header
`timescale 1ns/100ps
`include "ext_cfg.svh"

module tb_ext_top;
	import ext_pkg::*;

	`include "tb_ext_model.svh"

	localparam logic [31:0] SEED = 32'h13f53ce7;
	localparam int N_GROUPS   = 400;
	localparam int MAX_CYCLES = 4000;
	localparam int MAX_DRAIN  = 100;

	logic                      clk = 1'b0;
	logic                      rst_i;
	logic                      in_valid_i;
	logic                      in_ready_o;
	logic [`EXT_PC_BITS-1:0]   pc0_i;
	logic [`EXT_LINE_BITS-1:0] cline_i;
	logic                      irq_i;
	logic [`EXT_IPL_BITS-1:0]  ipl_i;
	logic                      ssm_i;
	logic                      miss_i;
	logic [`EXT_PC_BITS-1:0]   miss_pc_i;
	logic                      out_valid_o;
	logic                      out_ready_i;
	logic [`EXT_PC_BITS-1:0]   pc0_o;
	insn_slots_t               slots_o;
	slot_mask_t                slot_valid_o;
	logic                      hwi_o;
	logic [`EXT_IPL_BITS-1:0]  old_ipl_o;
	logic                      do_branch_o;
	logic                      do_call_o;
	logic                      do_ret_o;
	logic [`EXT_PC_BITS-1:0]   target_o;
	logic [`EXT_PC_BITS-1:0]   ret_pc_o;

	// Model history mirroring the former's state
	logic                      prev_valid;
	logic                      prev_ssm;
	logic [`EXT_PC_BITS-1:0]   prev_pc0;
	logic [WIN_BITS-1:0]       prev_win;

	// Scoreboard
	group_t exp_grp[$];
	flow_t  exp_flow[$];
	logic   fired;
	int     cyc;
	int     n_acc;
	int     n_redundant;
	int     n_call;
	int     n_ret;

	ext_top dut (.*);

	always #20 clk = ~clk;

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_field(string name, logic [WIN_BITS-1:0] got, logic [WIN_BITS-1:0] exp);
		assert (got === exp)
		else fail_run($sformatf("ERROR %s got %0h expected %0h", name, got, exp));
	endtask

	// Run one accepted input through the model
	task automatic accept_input();
		logic [WIN_BITS-1:0] win;
		logic                redundant;
		group_t              g;
		win          = align_window(cline_i, pc0_i);
		redundant    = prev_valid && (prev_pc0 == pc0_i) && (prev_win == win);
		g.pc0        = pc0_i;
		g.slots      = win;
		g.slot_valid = expect_mask(pc0_i, irq_i, redundant, miss_i, miss_pc_i, ssm_i, prev_ssm);
		g.hwi        = irq_i;
		g.old_ipl    = ipl_i;
		exp_grp.push_back(g);
		exp_flow.push_back(expect_flow(g));
		if (redundant)
			n_redundant++;
		prev_valid = 1'b1;
		prev_ssm   = ssm_i;
		prev_pc0   = pc0_i;
		prev_win   = win;
		n_acc++;
	endtask

	// Compare one output transfer with the oldest expected group
	task automatic check_output();
		group_t g;
		flow_t  f;
		g = exp_grp.pop_front();
		f = exp_flow.pop_front();
		check_field("pc0_o", pc0_o, g.pc0);
		check_field("slots_o", slots_o, g.slots);
		check_field("slot_valid_o", slot_valid_o, g.slot_valid);
		check_field("hwi_o", hwi_o, g.hwi);
		check_field("old_ipl_o", old_ipl_o, g.old_ipl);
		check_field("do_branch_o", do_branch_o, f.do_branch);
		check_field("do_call_o", do_call_o, f.do_call);
		check_field("do_ret_o", do_ret_o, f.do_ret);
		check_field("target_o", target_o, f.target);
		check_field("ret_pc_o", ret_pc_o, f.ret_pc);
		if (f.do_call)
			n_call++;
		if (f.do_ret)
			n_ret++;
	endtask

	// New group only once the held one is taken
	task automatic drive_inputs();
		out_ready_i = (cyc < 8) || ($urandom_range(0, 3) != 0);
		if (fired || !in_valid_i) begin
			in_valid_i = ($urandom_range(0, 4) != 0);
			// Otherwise keep pc and line for an exact repeat
			if (n_acc == 0 || $urandom_range(0, 5) != 0) begin
				pc0_i   = $urandom & 32'hFFFF_FFFE;
				cline_i = rand_line(pc0_i);
			end
			irq_i     = ($urandom_range(0, 15) == 0);
			ipl_i     = $urandom_range(0, 63);
			miss_i    = ($urandom_range(0, 5) == 0);
			miss_pc_i = pc0_i + $urandom_range(0, 30) - 32'd6;
			// Single step comes in runs
			if ($urandom_range(0, 7) == 0)
				ssm_i = !ssm_i;
		end
	endtask

	// Runs 1 ns after the falling edge once all outputs have settled
	task automatic evaluate();
		// Ready drops only while both output entries are occupied
		check_field("in_ready_o", in_ready_o, exp_grp.size() < 2);
		// Anything outstanding has to be showing by now
		if (exp_grp.size() != 0) begin
			assert (out_valid_o) else fail_run("out_valid_o low while groups were pending");
		end else begin
			assert (!out_valid_o) else fail_run("out_valid_o high with no group pending");
		end
		if (out_valid_o && out_ready_i)
			check_output();
		fired = in_valid_i && in_ready_o;
		if (fired)
			accept_input();
	endtask

	initial begin
		int drain;
		void'($urandom(SEED));
		rst_i       = 1'b1;
		in_valid_i  = 1'b0;
		out_ready_i = 1'b0;
		pc0_i       = '0;
		cline_i     = '0;
		irq_i       = 1'b0;
		ipl_i       = '0;
		ssm_i       = 1'b0;
		miss_i      = 1'b0;
		miss_pc_i   = '0;
		prev_valid  = 1'b0;
		prev_ssm    = 1'b0;
		prev_pc0    = '0;
		prev_win    = '0;
		fired       = 1'b0;
		cyc         = 0;
		n_acc       = 0;
		n_redundant = 0;
		n_call      = 0;
		n_ret       = 0;

		// ====================
		// Reset
		// ====================
		repeat (4) @(negedge clk);
		assert (!in_ready_o && !out_valid_o) else fail_run("Handshake outputs active during reset");
		rst_i = 1'b0;
		@(negedge clk);
		#1;
		assert (in_ready_o) else fail_run("in_ready_o did not rise on the first cycle after reset");
		assert (!out_valid_o) else fail_run("out_valid_o high right after reset");

		// ====================
		// Random traffic
		// ====================
		while (n_acc < N_GROUPS) begin
			@(negedge clk);
			drive_inputs();
			#1;
			evaluate();
			cyc++;
			assert (cyc < MAX_CYCLES)
			else fail_run("Timed out waiting for input groups to be accepted");
		end

		// Let the skid register empty out
		drain = 0;
		while (exp_grp.size() != 0) begin
			@(negedge clk);
			in_valid_i  = 1'b0;
			out_ready_i = ($urandom_range(0, 3) != 0);
			#1;
			evaluate();
			drain++;
			assert (drain < MAX_DRAIN) else fail_run("Timed out draining the output register");
		end

		assert (n_redundant > 0) else fail_run("Stimulus never produced a repeated group");
		assert (n_call > 0 && n_ret > 0)
		else fail_run("Stimulus never produced a call and a return");
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== ext_top.sv ====
// Instruction-extract stage of the superscalar front end
// Takes one fetch group per handshake and delivers the aligned, masked
// slots with the first control-flow decision one cycle later
`timescale 1ns/100ps
`include "ext_cfg.svh"

module ext_top (
	input  logic                      clk,
	input  logic                      rst_i,
	// Fetch side
	input  logic                      in_valid_i,
	output logic                      in_ready_o,
	input  logic [`EXT_PC_BITS-1:0]   pc0_i,
	input  logic [`EXT_LINE_BITS-1:0] cline_i,
	input  logic                      irq_i,
	input  logic [`EXT_IPL_BITS-1:0]  ipl_i,
	input  logic                      ssm_i,
	input  logic                      miss_i,
	input  logic [`EXT_PC_BITS-1:0]   miss_pc_i,
	// Decode side
	output logic                      out_valid_o,
	input  logic                      out_ready_i,
	output logic [`EXT_PC_BITS-1:0]   pc0_o,
	output ext_pkg::insn_slots_t      slots_o,
	output ext_pkg::slot_mask_t       slot_valid_o,
	output logic                      hwi_o,
	output logic [`EXT_IPL_BITS-1:0]  old_ipl_o,
	output logic                      do_branch_o,
	output logic                      do_call_o,
	output logic                      do_ret_o,
	output logic [`EXT_PC_BITS-1:0]   target_o,
	output logic [`EXT_PC_BITS-1:0]   ret_pc_o
);
	import ext_pkg::*;

	group_t out_grp;
	flow_t  out_flow;

	ext_group_if grp_if ();

	ext_group_former u_former (
		.clk       (clk),
		.rst_i     (rst_i),
		.in_valid_i(in_valid_i),
		.pc0_i     (pc0_i),
		.cline_i   (cline_i),
		.irq_i     (irq_i),
		.ipl_i     (ipl_i),
		.ssm_i     (ssm_i),
		.miss_i    (miss_i),
		.miss_pc_i (miss_pc_i),
		.grp       (grp_if.former)
	);

	ext_flow_select u_select (
		.grp(grp_if.sel)
	);

	ext_skid_reg u_skid (
		.clk        (clk),
		.rst_i      (rst_i),
		.grp        (grp_if.sel),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.group_o    (out_grp),
		.flow_o     (out_flow)
	);

	// Fetch sees the skid register's ready directly
	assign in_ready_o = grp_if.ready;

	// Split registered result into plain ports
	assign pc0_o        = out_grp.pc0;
	assign slots_o      = out_grp.slots;
	assign slot_valid_o = out_grp.slot_valid;
	assign hwi_o        = out_grp.hwi;
	assign old_ipl_o    = out_grp.old_ipl;
	assign do_branch_o  = out_flow.do_branch;
	assign do_call_o    = out_flow.do_call;
	assign do_ret_o     = out_flow.do_ret;
	assign target_o     = out_flow.target;
	assign ret_pc_o     = out_flow.ret_pc;

endmodule

// ==== ext_skid_reg.sv ====
// Two-entry output register between the extract logic and the decoder
// Ready toward the former is registered and drops only when both entries
// are full, items leave in arrival order
`timescale 1ns/100ps

module ext_skid_reg (
	input  logic           clk,
	input  logic           rst_i,
	ext_group_if.sel       grp,
	output logic           out_valid_o,
	input  logic           out_ready_i,
	output ext_pkg::group_t group_o,
	output ext_pkg::flow_t  flow_o
);
	import ext_pkg::*;

	logic   in_fire;
	logic   main_v_q, main_v_d;
	logic   skid_v_q, skid_v_d;
	logic   ready_q;
	logic   load_main_in;
	logic   load_main_skid;
	logic   load_skid;
	group_t main_grp_q, skid_grp_q;
	flow_t  main_flow_q, skid_flow_q;

	assign in_fire = grp.valid && ready_q;

	// Next occupancy and which register loads from where
	always_comb begin
		main_v_d       = main_v_q;
		skid_v_d       = skid_v_q;
		load_main_in   = 1'b0;
		load_main_skid = 1'b0;
		load_skid      = 1'b0;
		if (!main_v_q || out_ready_i) begin
			// Main frees up, oldest item moves in first
			if (skid_v_q) begin
				load_main_skid = 1'b1;
				main_v_d       = 1'b1;
				load_skid      = in_fire;
				skid_v_d       = in_fire;
			end else begin
				load_main_in = in_fire;
				main_v_d     = in_fire;
			end
		end else if (in_fire) begin
			// Output stalled, park the new item
			load_skid = 1'b1;
			skid_v_d  = 1'b1;
		end
	end

	// Control state
	always_ff @(posedge clk) begin
		if (rst_i) begin
			main_v_q <= 1'b0;
			skid_v_q <= 1'b0;
			ready_q  <= 1'b0;
		end else begin
			main_v_q <= main_v_d;
			skid_v_q <= skid_v_d;
			ready_q  <= !(main_v_d && skid_v_d);
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (load_main_skid) begin
			main_grp_q  <= skid_grp_q;
			main_flow_q <= skid_flow_q;
		end else if (load_main_in) begin
			main_grp_q  <= grp.group;
			main_flow_q <= grp.flow;
		end
		if (load_skid) begin
			skid_grp_q  <= grp.group;
			skid_flow_q <= grp.flow;
		end
	end

	assign grp.ready   = ready_q;
	assign out_valid_o = main_v_q;
	assign group_o     = main_grp_q;
	assign flow_o      = main_flow_q;

endmodule

// ==== ext_flow_select.sv ====
// Finds the first call, branch or return among the valid slots of a group
// Also picks the return address of the lowest valid call
// Purely combinational, result travels next to the group on the link
`timescale 1ns/100ps
`include "ext_cfg.svh"

module ext_flow_select (
	ext_group_if.sel grp
);
	import ext_pkg::*;

	localparam logic [`EXT_PC_BITS-1:0] INSN_BYTES = `EXT_INSN_BITS / 8;

	logic [`EXT_PC_BITS-1:0] slot_pc  [`EXT_SLOTS];
	logic [`EXT_PC_BITS-1:0] slot_tgt [`EXT_SLOTS];
	logic [`EXT_SLOTS-1:0]   is_call;
	logic [`EXT_SLOTS-1:0]   is_jump;
	logic [`EXT_SLOTS-1:0]   is_ret;
	logic                    found;
	flow_t                   flow;

	// ====================
	// Per-slot decode
	// ====================

	for (genvar n = 0; n < `EXT_SLOTS; n++) begin : g_dec
		assign slot_pc[n] = grp.group.pc0 + INSN_BYTES * n;

		ext_branch_decode u_dec (
			.slot_pc_i (slot_pc[n]),
			.insn_i    (grp.group.slots[n]),
			.is_call_o (is_call[n]),
			.is_jump_o (is_jump[n]),
			.is_ret_o  (is_ret[n]),
			.target_o  (slot_tgt[n])
		);
	end

	// ====================
	// Priority pick
	// ====================

	always_comb begin
		flow.do_branch = 1'b0;
		flow.do_call   = 1'b0;
		flow.do_ret    = 1'b0;
		flow.target    = `EXT_RESET_PC;
		flow.ret_pc    = `EXT_RESET_PC;
		found          = 1'b0;

		// Lowest valid slot with a jump or return wins
		for (int i = 0; i < `EXT_SLOTS; i++) begin
			if (!found && grp.group.slot_valid[i]) begin
				if (is_jump[i]) begin
					found          = 1'b1;
					flow.do_branch = 1'b1;
					flow.do_call   = is_call[i];
					flow.target    = slot_tgt[i];
				end else if (is_ret[i]) begin
					// Return target comes from the return stack later
					found       = 1'b1;
					flow.do_ret = 1'b1;
				end
			end
		end

		// Walk downward so the lowest valid call is left standing
		for (int i = `EXT_SLOTS - 1; i >= 0; i--) begin
			if (grp.group.slot_valid[i] && is_call[i])
				flow.ret_pc = slot_pc[i] + INSN_BYTES;
		end
	end

	assign grp.flow = flow;

endmodule

// ==== ext_group_former.sv ====
// Forms one instruction group per accepted fetch
// Aligns the cache line to the PC parcel, cuts four slots and masks them
// for interrupt, branch miss, single step and repeated groups
`timescale 1ns/100ps
`include "ext_cfg.svh"

module ext_group_former (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     in_valid_i,
	input  logic [`EXT_PC_BITS-1:0]  pc0_i,
	input  logic [`EXT_LINE_BITS-1:0] cline_i,
	input  logic                     irq_i,
	input  logic [`EXT_IPL_BITS-1:0] ipl_i,
	input  logic                     ssm_i,
	input  logic                     miss_i,
	input  logic [`EXT_PC_BITS-1:0]  miss_pc_i,
	ext_group_if.former              grp
);
	import ext_pkg::*;

	// Top bit of the parcel index within a line
	localparam int PIDX_HI = $clog2(`EXT_LINE_BITS / 8) - 1;
	localparam int WIN_BITS = `EXT_SLOTS * `EXT_INSN_BITS;
	localparam logic [`EXT_PC_BITS-1:0] INSN_BYTES = `EXT_INSN_BITS / 8;

	logic [`EXT_LINE_BITS-1:0] line_shifted;
	insn_slots_t               window;
	logic                      accept;
	logic                      redundant;
	slot_mask_t                slot_valid;
	group_t                    grp_d;

	// Previous accepted group
	logic                      prev_valid_q;
	logic                      prev_ssm_q;
	logic [`EXT_PC_BITS-1:0]   prev_pc0_q;
	insn_slots_t               prev_window_q;

	// ====================
	// Alignment
	// ====================

	// Shift by parcel index, vacated bits fill with zero which decodes as NOP
	assign line_shifted = cline_i >> (pc0_i[PIDX_HI:1] * `EXT_PARCEL_BITS);
	assign window = line_shifted[WIN_BITS-1:0];

	// Input handshake passes straight through
	assign accept = in_valid_i && grp.ready;

	// Same PC and same aligned bits as last time means nothing new
	assign redundant = prev_valid_q && (prev_pc0_q == pc0_i) && (prev_window_q == window);

	// ====================
	// Slot masking
	// ====================

	for (genvar n = 0; n < `EXT_SLOTS; n++) begin : g_slot
		logic [`EXT_PC_BITS-1:0] slot_pc;
		logic                    miss_kill;
		logic                    step_kill;

		assign slot_pc = pc0_i + INSN_BYTES * n;
		// Slots ahead of the miss PC belong to the wrong path
		assign miss_kill = miss_i && (miss_pc_i > slot_pc);
		// Single step lets slot 0 through once only
		assign step_kill = ssm_i && ((n != 0) || prev_ssm_q);
		assign slot_valid[n] = !(irq_i || redundant || miss_kill || step_kill);
	end

	// Assemble outgoing group
	always_comb begin
		grp_d.pc0        = pc0_i;
		grp_d.slots      = window;
		grp_d.slot_valid = slot_valid;
		grp_d.hwi        = irq_i;
		grp_d.old_ipl    = ipl_i;
	end

	assign grp.valid = in_valid_i;
	assign grp.group = grp_d;

	// ====================
	// History state
	// ====================

	// Control flags, advance only on an accepted input
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_valid_q <= 1'b0;
			prev_ssm_q   <= 1'b0;
		end else if (accept) begin
			prev_valid_q <= 1'b1;
			prev_ssm_q   <= ssm_i;
		end
	end

	// Compare data, only looked at once prev_valid_q is set
	always_ff @(posedge clk) begin
		if (accept) begin
			prev_pc0_q    <= pc0_i;
			prev_window_q <= window;
		end
	end

endmodule

// ==== ext_branch_decode.sv ====
// Classifies one slot for control flow and computes its target
// One instance per slot inside the flow select
`timescale 1ns/100ps
`include "ext_cfg.svh"

module ext_branch_decode (
	input  logic [`EXT_PC_BITS-1:0] slot_pc_i,
	input  ext_pkg::insn_word_u     insn_i,
	output logic                    is_call_o,
	output logic                    is_jump_o,
	output logic                    is_ret_o,
	output logic [`EXT_PC_BITS-1:0] target_o
);

	logic [6:0] op;

	// Opcode field is in the same place in both views
	assign op = insn_i.br_short.opcode;

	// Calls push a return address
	assign is_call_o = (op == `EXT_OP_BSR) || (op == `EXT_OP_JSR);

	// Anything that redirects to a computed target
	assign is_jump_o = is_call_o || (op == `EXT_OP_BCC);

	assign is_ret_o = (op == `EXT_OP_RTD);

	// Target per form
	always_comb begin
		case (op)
			// PC relative, disp is already full width and signed
			`EXT_OP_BSR,
			`EXT_OP_BCC: target_o = slot_pc_i + insn_i.br_short.disp;
			// Absolute, upper address bits are ignored
			`EXT_OP_JSR: target_o = insn_i.jmp_long.addr[`EXT_PC_BITS-1:0];
			default:     target_o = `EXT_RESET_PC;
		endcase
	end

endmodule

// ==== ext_group_if.sv ====
// Internal link from the group former to the skid register
// The former drives the group, the select side adds flow and returns ready
`timescale 1ns/100ps

interface ext_group_if;
	import ext_pkg::*;

	// Handshake
	logic   valid;
	logic   ready;

	// Payload
	group_t group;
	flow_t  flow;

	// Producer side
	modport former (
		output valid,
		output group,
		input  ready
	);

	// Consumer side, flow select drives flow and skid register drives ready
	modport sel (
		input  valid,
		input  group,
		output flow,
		output ready
	);

endinterface

// ==== ext_pkg.sv ====
// Shared types of the instruction-extract stage
// Instruction word views, slot arrays, the formed group and the flow result
`include "ext_cfg.svh"

package ext_pkg;

	// ====================
	// Instruction word
	// ====================

	// Short branch form, used by BSR and BCC
	typedef struct packed {
		logic signed [31:0] disp;    // Byte displacement from slot PC
		logic [5:0]         rs1;
		logic [2:0]         cond;
		logic [6:0]         opcode;
	} insn_br_short_t;

	// Long jump form, used by JSR
	typedef struct packed {
		logic [40:0] addr;           // Absolute target in low 32 bits
		logic [6:0]  opcode;
	} insn_jmp_long_t;

	// Same 48 bits read either way, opcode sits at the bottom in both
	typedef union packed {
		insn_br_short_t br_short;
		insn_jmp_long_t jmp_long;
	} insn_word_u;

	// ====================
	// Group types
	// ====================

	// Four slots, slot 0 in the low bits
	typedef insn_word_u [`EXT_SLOTS-1:0] insn_slots_t;

	// One valid bit per slot
	typedef logic [`EXT_SLOTS-1:0] slot_mask_t;

	// Control-flow result for one group
	typedef struct packed {
		logic                    do_branch;
		logic                    do_call;
		logic                    do_ret;
		logic [`EXT_PC_BITS-1:0] target;
		logic [`EXT_PC_BITS-1:0] ret_pc;
	} flow_t;

	// Aligned group as handed to the flow select and skid register
	typedef struct packed {
		logic [`EXT_PC_BITS-1:0]  pc0;
		insn_slots_t              slots;
		slot_mask_t               slot_valid;
		logic                     hwi;
		logic [`EXT_IPL_BITS-1:0] old_ipl;
	} group_t;

endpackage

// ==== ext_cfg.svh ====
// Widths, slot count, opcodes and reset PC for the instruction-extract stage
// Included by the package and by every module that sizes a port or decodes
`ifndef EXT_CFG_SVH
`define EXT_CFG_SVH

// Group geometry
`define EXT_SLOTS       4
`define EXT_INSN_BITS   48
`define EXT_PARCEL_BITS 16
`define EXT_LINE_BITS   512
`define EXT_PC_BITS     32
`define EXT_IPL_BITS    6

// Default target and return address when nothing is found
`define EXT_RESET_PC    32'hFFFC0000

// Reduced opcode set, anything else is ordinary
`define EXT_OP_NOP      7'h00
`define EXT_OP_BSR      7'h20
`define EXT_OP_JSR      7'h21
`define EXT_OP_BCC      7'h22
`define EXT_OP_RTD      7'h23

`endif
